//--- hdl/dts_rx_params.svh
`ifndef DTS_RX_PARAMS_SVH
`define DTS_RX_PARAMS_SVH

// Channel count and word geometry
`define RX_N_CHAN        4
`define RX_WORD_W        40
`define RX_PAYLOAD_W     32

// Header marker sits in the top bits of the gearbox word
`define RX_SYNC_W        5
`define RX_SYNC_PATTERN  5'b10110

// Lock acquisition
`define RX_LOCK_COUNT    8   // consecutive good headers
`define RX_HOLDOFF       16  // words ignored after a slip

// Offsetter depth range
`define RX_DEPTH_W       4
`define RX_DEPTH_MAX     15
`define RX_DEPTH_RESET   4

`endif

//--- hdl/dts_rx_pkg.sv
`include "dts_rx_params.svh"

package dts_rx_pkg;

  // One deformatted frame with flags in header order
  typedef struct packed {
    logic [`RX_PAYLOAD_W-1:0] payload;
    logic                     ten_sec;
    logic                     one_sec;
    logic                     index;
  } rx_frame_t;

  // Source channel number for the reorder crossbar
  typedef logic [$clog2(`RX_N_CHAN)-1:0] chan_sel_t;

endpackage

//--- hdl/dts_deformatter.sv
`include "dts_rx_params.svh"

module dts_deformatter (
  input  logic                  gt_clkout,
  input  logic                  arst_n_i,
  input  logic [`RX_WORD_W-1:0] rx_word_i,
  output logic                  slip_o,
  output dts_rx_pkg::rx_frame_t frame_o,
  output logic                  frame_valid_o,
  output logic                  locked_o
);
  import dts_rx_pkg::*;

  localparam int unsigned MARK_LSB = `RX_WORD_W - `RX_SYNC_W;
  localparam int unsigned GOOD_W   = $clog2(`RX_LOCK_COUNT);
  localparam int unsigned HOLD_W   = $clog2(`RX_HOLDOFF + 1);

  localparam logic [GOOD_W-1:0] GOOD_LAST = GOOD_W'(`RX_LOCK_COUNT - 1);
  localparam logic [HOLD_W-1:0] HOLD_LOAD = HOLD_W'(`RX_HOLDOFF);

  rx_frame_t         frame_q;
  logic [GOOD_W-1:0] good_cnt_q;
  logic [HOLD_W-1:0] hold_cnt_q;
  logic              locked_q;
  logic              slip_q;
  logic              hdr_ok;
  logic              in_holdoff;

  ////////////////////
  // Header search
  ////////////////////

  assign hdr_ok     = (rx_word_i[`RX_WORD_W-1:MARK_LSB] == `RX_SYNC_PATTERN);
  assign in_holdoff = (hold_cnt_q != '0);   // Gearbox still settling

  // Lock and slip state.
  // A slip is only requested while unlocked; a locked channel that sees
  // a bad header just falls back to counting without moving the gearbox.
  always_ff @(posedge gt_clkout or negedge arst_n_i) begin
    if (!arst_n_i) begin
      good_cnt_q <= '0;
      hold_cnt_q <= '0;
      locked_q   <= 1'b0;
      slip_q     <= 1'b0;
    end else begin
      slip_q <= 1'b0;                       // Single cycle pulse
      if (in_holdoff) begin
        hold_cnt_q <= hold_cnt_q - 1'b1;
        good_cnt_q <= '0;                   // Words here do not count
      end else if (hdr_ok) begin
        if (good_cnt_q == GOOD_LAST) begin
          locked_q <= 1'b1;                 // Saturate and hold lock
        end else begin
          good_cnt_q <= good_cnt_q + 1'b1;
        end
      end else begin
        good_cnt_q <= '0;
        locked_q   <= 1'b0;
        if (!locked_q) begin
          slip_q     <= 1'b1;
          hold_cnt_q <= HOLD_LOAD;
        end
      end
    end
  end

  ////////////////////
  // Payload extract
  ////////////////////

  // Header flags ten_sec, one_sec and index sit just above the payload
  always_ff @(posedge gt_clkout) begin
    frame_q <= {rx_word_i[`RX_PAYLOAD_W-1:0],
                rx_word_i[`RX_PAYLOAD_W+2:`RX_PAYLOAD_W]};
  end

  assign frame_o       = frame_q;
  assign frame_valid_o = locked_q;          // Frame is good only once locked
  assign locked_o      = locked_q;
  assign slip_o        = slip_q;

  // Gearbox must not see two slips inside the settle window
  a_slip_spacing : assert property (
    @(posedge gt_clkout) disable iff (!arst_n_i)
    slip_q |=> !slip_q [*`RX_HOLDOFF]
  );

  // Lock cannot come back while the holdoff words are still passing
  a_no_lock_in_holdoff : assert property (
    @(posedge gt_clkout) disable iff (!arst_n_i)
    slip_q |-> !locked_q [*`RX_HOLDOFF + 1]
  );

endmodule

//--- hdl/dts_reorder.sv
`include "dts_rx_params.svh"

module dts_reorder (
  input  logic                   gt_clkout,
  input  logic                   arst_n_i,
  input  dts_rx_pkg::chan_sel_t  sel_i,
  input  dts_rx_pkg::rx_frame_t  frames_i [`RX_N_CHAN],
  input  logic [`RX_N_CHAN-1:0]  valids_i,
  output dts_rx_pkg::rx_frame_t  frame_o,
  output logic                   frame_valid_o
);
  import dts_rx_pkg::*;

  rx_frame_t frame_q;
  logic      valid_q;

  // Selected frame
  always_ff @(posedge gt_clkout) begin
    frame_q <= frames_i[sel_i];
  end

  // Valid follows the same source so a select change lands on a word edge
  always_ff @(posedge gt_clkout or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valids_i[sel_i];
    end
  end

  assign frame_o       = frame_q;
  assign frame_valid_o = valid_q;

endmodule

//--- hdl/dts_offsetter.sv
`include "dts_rx_params.svh"

module dts_offsetter (
  input  logic                   gt_clkout,
  input  logic                   arst_n_i,
  input  logic                   offset_rst_i,
  input  logic                   advance_i,
  input  logic                   delay_i,
  input  dts_rx_pkg::rx_frame_t  frame_i,
  input  logic                   frame_valid_i,
  output dts_rx_pkg::rx_frame_t  frame_o,
  output logic                   frame_valid_o,
  output logic [`RX_DEPTH_W-1:0] depth_o
);
  import dts_rx_pkg::*;

  localparam int unsigned N_TAP = `RX_DEPTH_MAX + 1;

  localparam logic [`RX_DEPTH_W-1:0] DEPTH_MAX = `RX_DEPTH_W'(`RX_DEPTH_MAX);
  localparam logic [`RX_DEPTH_W-1:0] DEPTH_RST = `RX_DEPTH_W'(`RX_DEPTH_RESET);

  rx_frame_t                line_q [`RX_DEPTH_MAX];
  logic [`RX_DEPTH_MAX-1:0] vld_line_q;
  rx_frame_t                tap [N_TAP];
  logic [N_TAP-1:0]         tap_vld;
  logic [`RX_DEPTH_W-1:0]   depth_q;
  logic [`RX_PAYLOAD_W-1:0] payload_q;
  logic [2:0]               flags_q;
  logic                     valid_q;

  ////////////////////
  // Delay line
  ////////////////////

  assign tap[0]     = frame_i;              // Depth 0 taps the input
  assign tap_vld[0] = frame_valid_i;

  for (genvar i = 1; i < N_TAP; i++) begin : g_tap
    assign tap[i] = line_q[i-1];
  end
  assign tap_vld[N_TAP-1:1] = vld_line_q;

  always_ff @(posedge gt_clkout) begin
    line_q[0] <= frame_i;
    for (int i = 1; i < `RX_DEPTH_MAX; i++) begin
      line_q[i] <= line_q[i-1];
    end
  end

  always_ff @(posedge gt_clkout or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vld_line_q <= '0;
    end else begin
      vld_line_q <= {vld_line_q[`RX_DEPTH_MAX-2:0], frame_valid_i};
    end
  end

  // Saturating depth control
  always_ff @(posedge gt_clkout or negedge arst_n_i) begin
    if (!arst_n_i) begin
      depth_q <= DEPTH_RST;
    end else if (offset_rst_i) begin
      depth_q <= DEPTH_RST;
    end else if (advance_i && depth_q != '0) begin
      depth_q <= depth_q - 1'b1;
    end else if (delay_i && depth_q != DEPTH_MAX) begin
      depth_q <= depth_q + 1'b1;
    end
  end

  ////////////////////
  // Output tap
  ////////////////////

  always_ff @(posedge gt_clkout) begin
    payload_q <= tap[depth_q].payload;
  end

  // Flags held low whenever the tapped word is not valid
  always_ff @(posedge gt_clkout or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      flags_q <= '0;
    end else begin
      valid_q <= tap_vld[depth_q];
      flags_q <= tap_vld[depth_q] ?
                 {tap[depth_q].ten_sec, tap[depth_q].one_sec, tap[depth_q].index} : 3'b000;
    end
  end

  assign frame_o       = {payload_q, flags_q};
  assign frame_valid_o = valid_q;
  assign depth_o       = depth_q;

  a_depth_range : assert property (
    @(posedge gt_clkout) disable iff (!arst_n_i)
    depth_q <= DEPTH_MAX
  );

  // Register block never issues both pulses together
  a_adv_dly_excl : assert property (
    @(posedge gt_clkout) disable iff (!arst_n_i)
    !(advance_i && delay_i)
  );

endmodule

//--- hdl/dts_rx_regs.sv
`include "dts_rx_params.svh"

module dts_rx_regs (
  input  logic                               gt_clkout,
  input  logic                               arst_n_i,
  input  logic                               reg_we_i,
  input  logic                               reg_re_i,
  input  logic [3:0]                         reg_addr_i,
  input  logic [31:0]                        reg_wdata_i,
  output logic [31:0]                        reg_rdata_o,
  input  logic [`RX_N_CHAN-1:0]              locked_i,
  input  logic [`RX_DEPTH_W*`RX_N_CHAN-1:0]  depth_i,
  output dts_rx_pkg::chan_sel_t              sel_o [`RX_N_CHAN],
  output logic [`RX_N_CHAN-1:0]              advance_o,
  output logic [`RX_N_CHAN-1:0]              delay_o,
  output logic                               offset_rst_o
);
  import dts_rx_pkg::*;

  localparam int unsigned SEL_W = $bits(chan_sel_t);

  // Register map
  localparam logic [3:0] ADDR_CTRL    = 4'd0;
  localparam logic [3:0] ADDR_MUX     = 4'd1;
  localparam logic [3:0] ADDR_ADVANCE = 4'd2;
  localparam logic [3:0] ADDR_DELAY   = 4'd3;
  localparam logic [3:0] ADDR_STATUS  = 4'd4;
  localparam logic [3:0] ADDR_DEPTH   = 4'd5;

  chan_sel_t                   sel_q [`RX_N_CHAN];
  logic [SEL_W*`RX_N_CHAN-1:0] mux_rd;
  logic [31:0]                 rd_data;
  logic                        wr_ctrl;
  logic                        wr_mux;
  logic                        wr_adv;
  logic                        wr_dly;

  assign wr_ctrl = reg_we_i && (reg_addr_i == ADDR_CTRL);
  assign wr_mux  = reg_we_i && (reg_addr_i == ADDR_MUX);
  assign wr_adv  = reg_we_i && (reg_addr_i == ADDR_ADVANCE);
  assign wr_dly  = reg_we_i && (reg_addr_i == ADDR_DELAY);

  ////////////////////
  // MUX register
  ////////////////////

  always_ff @(posedge gt_clkout or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int k = 0; k < `RX_N_CHAN; k++) begin
        sel_q[k] <= chan_sel_t'(k);         // Identity map
      end
    end else if (wr_mux) begin
      for (int k = 0; k < `RX_N_CHAN; k++) begin
        sel_q[k] <= reg_wdata_i[k*SEL_W +: SEL_W];
      end
    end
  end

  for (genvar k = 0; k < `RX_N_CHAN; k++) begin : g_mux_rd
    assign mux_rd[k*SEL_W +: SEL_W] = sel_q[k];
  end
  assign sel_o = sel_q;

  // Write strobes become one-cycle pulses
  always_ff @(posedge gt_clkout or negedge arst_n_i) begin
    if (!arst_n_i) begin
      offset_rst_o <= 1'b0;
      advance_o    <= '0;
      delay_o      <= '0;
    end else begin
      offset_rst_o <= wr_ctrl && reg_wdata_i[0];
      advance_o    <= wr_adv ? reg_wdata_i[`RX_N_CHAN-1:0] : '0;
      delay_o      <= wr_dly ? reg_wdata_i[`RX_N_CHAN-1:0] : '0;
    end
  end

  ////////////////////
  // Read back
  ////////////////////

  always_comb begin
    case (reg_addr_i)
      ADDR_MUX:    rd_data = 32'(mux_rd);
      ADDR_STATUS: rd_data = 32'(locked_i);
      ADDR_DEPTH:  rd_data = 32'(depth_i);
      default:     rd_data = '0;          // CTRL and pulse regs read zero
    endcase
  end

  always_ff @(posedge gt_clkout or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reg_rdata_o <= '0;
    end else if (reg_re_i) begin
      reg_rdata_o <= rd_data;
    end
  end

  a_adv_pulse : assert property (
    @(posedge gt_clkout) disable iff (!arst_n_i)
    wr_adv |=> (advance_o == $past(reg_wdata_i[`RX_N_CHAN-1:0]))
  );

endmodule

//--- hdl/dts_rx.sv
`include "dts_rx_params.svh"

module dts_rx (
  input  logic                     gt_clkout,
  input  logic                     arst_n_i,
  input  logic [`RX_WORD_W-1:0]    rx_data_i [`RX_N_CHAN],
  output logic [`RX_N_CHAN-1:0]    slip_o,
  input  logic                     reg_we_i,
  input  logic                     reg_re_i,
  input  logic [3:0]               reg_addr_i,
  input  logic [31:0]              reg_wdata_i,
  output logic [31:0]              reg_rdata_o,
  output logic [`RX_PAYLOAD_W-1:0] frame_payload_o [`RX_N_CHAN],
  output logic [`RX_N_CHAN-1:0]    frame_valid_o,
  output logic [`RX_N_CHAN-1:0]    index_o,
  output logic [`RX_N_CHAN-1:0]    one_sec_o,
  output logic [`RX_N_CHAN-1:0]    ten_sec_o,
  output logic [`RX_N_CHAN-1:0]    locked_o
);
  import dts_rx_pkg::*;

  rx_frame_t                          def_frame [`RX_N_CHAN];
  logic [`RX_N_CHAN-1:0]              def_valid;
  rx_frame_t                          reo_frame [`RX_N_CHAN];
  logic [`RX_N_CHAN-1:0]              reo_valid;
  rx_frame_t                          off_frame [`RX_N_CHAN];
  chan_sel_t                          sel [`RX_N_CHAN];
  logic [`RX_N_CHAN-1:0]              advance;
  logic [`RX_N_CHAN-1:0]              delay;
  logic                               offset_rst;
  logic [`RX_DEPTH_W*`RX_N_CHAN-1:0]  depth;

  for (genvar c = 0; c < `RX_N_CHAN; c++) begin : g_chan
    dts_deformatter i_deformatter (
      .gt_clkout     (gt_clkout),
      .arst_n_i      (arst_n_i),
      .rx_word_i     (rx_data_i[c]),
      .slip_o        (slip_o[c]),
      .frame_o       (def_frame[c]),
      .frame_valid_o (def_valid[c]),
      .locked_o      (locked_o[c])
    );

    // Output c may pick any deformatter
    dts_reorder i_reorder (
      .gt_clkout     (gt_clkout),
      .arst_n_i      (arst_n_i),
      .sel_i         (sel[c]),
      .frames_i      (def_frame),
      .valids_i      (def_valid),
      .frame_o       (reo_frame[c]),
      .frame_valid_o (reo_valid[c])
    );

    dts_offsetter i_offsetter (
      .gt_clkout     (gt_clkout),
      .arst_n_i      (arst_n_i),
      .offset_rst_i  (offset_rst),
      .advance_i     (advance[c]),
      .delay_i       (delay[c]),
      .frame_i       (reo_frame[c]),
      .frame_valid_i (reo_valid[c]),
      .frame_o       (off_frame[c]),
      .frame_valid_o (frame_valid_o[c]),
      .depth_o       (depth[c*`RX_DEPTH_W +: `RX_DEPTH_W])
    );

    assign frame_payload_o[c] = off_frame[c].payload;
    assign index_o[c]         = off_frame[c].index;
    assign one_sec_o[c]       = off_frame[c].one_sec;
    assign ten_sec_o[c]       = off_frame[c].ten_sec;
  end

  dts_rx_regs i_regs (
    .gt_clkout    (gt_clkout),
    .arst_n_i     (arst_n_i),
    .reg_we_i     (reg_we_i),
    .reg_re_i     (reg_re_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_rdata_o  (reg_rdata_o),
    .locked_i     (locked_o),
    .depth_i      (depth),
    .sel_o        (sel),
    .advance_o    (advance),
    .delay_o      (delay),
    .offset_rst_o (offset_rst)
  );

endmodule

//--- testbench/tb_dts_rx.sv
`include "dts_rx_params.svh"

module tb_dts_rx;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned N          = `RX_N_CHAN;
  localparam int unsigned LOCK_BOUND = 40 * (`RX_HOLDOFF + `RX_LOCK_COUNT + 2);
  localparam int unsigned QUIET      = `RX_DEPTH_MAX + 3;
  localparam logic [`RX_WORD_W-1:0] HDR_FLIP = 40'h20_0000_0000;  // One marker bit

  logic                     gt_clkout;
  logic                     arst_n_i;
  logic [`RX_WORD_W-1:0]    rx_data [N];
  logic [N-1:0]             slip;
  logic                     reg_we;
  logic                     reg_re;
  logic [3:0]               reg_addr;
  logic [31:0]              reg_wdata;
  logic [31:0]              reg_rdata;
  logic [`RX_PAYLOAD_W-1:0] payload [N];
  logic [N-1:0]             valid;
  logic [N-1:0]             index;
  logic [N-1:0]             one_sec;
  logic [N-1:0]             ten_sec;
  logic [N-1:0]             locked;

  // Reference model state
  int unsigned cyc;
  int unsigned offset [N];
  int unsigned base [N];
  int unsigned exp_sel [N];
  int unsigned exp_depth [N];
  int unsigned last_slip [N];
  int unsigned slip_cnt [N];
  int unsigned chk_cnt [N];
  int unsigned quiet_until;
  logic [N-1:0] corrupt;
  logic         check_en;
  logic [31:0]  lfsr;
  int           n_mismatch;
  int           n_other;
  int           n_checks;

  dts_rx i_dts_rx (
    .gt_clkout       (gt_clkout),
    .arst_n_i        (arst_n_i),
    .rx_data_i       (rx_data),
    .slip_o          (slip),
    .reg_we_i        (reg_we),
    .reg_re_i        (reg_re),
    .reg_addr_i      (reg_addr),
    .reg_wdata_i     (reg_wdata),
    .reg_rdata_o     (reg_rdata),
    .frame_payload_o (payload),
    .frame_valid_o   (valid),
    .index_o         (index),
    .one_sec_o       (one_sec),
    .ten_sec_o       (ten_sec),
    .locked_o        (locked)
  );

  initial begin
    gt_clkout = 1'b0;
    forever #10 gt_clkout = ~gt_clkout;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int unsigned rand_bits(input int unsigned n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = (v << 1) | lfsr[0];
    end
    return v;
  endfunction

  // {ten_sec, one_sec, index} for a count
  function automatic logic [2:0] flag_bits(input logic [23:0] cnt);
    return {cnt[7:0] == 8'd0, cnt[5:0] == 6'd0, cnt[3:0] == 4'd0};
  endfunction

  function automatic logic [`RX_WORD_W-1:0] gear_word(input int unsigned c,
                                                      input int unsigned cnt,
                                                      input int unsigned rot);
    logic [23:0]           c24;
    logic [`RX_WORD_W-1:0] w;
    c24 = 24'(cnt);
    w   = {`RX_SYNC_PATTERN, flag_bits(c24), 8'(c), c24};
    return (w << rot) | (w >> (`RX_WORD_W - rot));  // Rotate left
  endfunction

  ////////////////////
  // Gearbox model
  ////////////////////

  always @(posedge gt_clkout) begin : drive_gearbox
    int unsigned rot;
    for (int c = 0; c < N; c++) begin
      rot = slip[c] ? (offset[c] + 1) % `RX_WORD_W : offset[c];
      offset[c]  <= rot;
      rx_data[c] <= gear_word(c, base[c] + cyc, rot) ^ (corrupt[c] ? HDR_FLIP : '0);
    end
    cyc <= cyc + 1;
  end

  // Slip spacing
  always @(posedge gt_clkout) begin
    for (int c = 0; c < N; c++) begin
      if (slip[c]) begin
        assert (slip_cnt[c] == 0 || cyc - last_slip[c] > `RX_HOLDOFF) else begin
          n_other++;
          $display("channel %0d slipped again %0d cycles after a slip at %0t",
                   c, cyc - last_slip[c], $time);
        end
        slip_cnt[c]  <= slip_cnt[c] + 1;
        last_slip[c] <= cyc;
      end
    end
  end

  ////////////////////
  // Output checks
  ////////////////////

  always @(posedge gt_clkout) begin : check_outputs
    logic [31:0] exp_word;
    for (int k = 0; k < N; k++) begin
      if (check_en && valid[k]) begin
        assert ({ten_sec[k], one_sec[k], index[k]} == flag_bits(payload[k][23:0])) else begin
          n_mismatch++;
          $display("mismatch at %0t: {ten_sec_o,one_sec_o,index_o}[%0d] expected %b actual %b",
                   $time, k, flag_bits(payload[k][23:0]),
                   {ten_sec[k], one_sec[k], index[k]});
        end
        if (cyc >= quiet_until) begin
          exp_word = {8'(exp_sel[k]), 24'(base[exp_sel[k]] + cyc - 4 - exp_depth[k])};
          n_checks++;
          chk_cnt[k]++;
          assert (payload[k] == exp_word) else begin
            n_mismatch++;
            $display("mismatch at %0t: frame_payload_o[%0d] expected %h actual %h",
                     $time, k, exp_word, payload[k]);
          end
        end
      end
    end
  end

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
    @(posedge gt_clkout);
    reg_we    <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(posedge gt_clkout);
    reg_we    <= 1'b0;
  endtask

  task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
    @(posedge gt_clkout);
    reg_re   <= 1'b1;
    reg_addr <= addr;
    @(posedge gt_clkout);
    reg_re   <= 1'b0;
    @(posedge gt_clkout);
    data = reg_rdata;
  endtask

  task automatic check_reg(input logic [3:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] got;
    read_reg(addr, got);
    assert (got == exp) else begin
      n_mismatch++;
      $display("mismatch at %0t: reg_rdata_o (%s) expected %h actual %h",
               $time, name, exp, got);
    end
  endtask

  // Advance (addr 2) or delay (addr 3) pulse with a model that saturates like the offsetter
  task automatic step_depth(input logic [3:0] addr, input logic [3:0] mask);
    write_reg(addr, 32'(mask));
    for (int k = 0; k < N; k++) begin
      if (mask[k] && addr == 4'd2 && exp_depth[k] > 0) begin
        exp_depth[k] <= exp_depth[k] - 1;
      end else if (mask[k] && addr == 4'd3 && exp_depth[k] < `RX_DEPTH_MAX) begin
        exp_depth[k] <= exp_depth[k] + 1;
      end
    end
    quiet_until <= cyc + QUIET + 4;
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin : stimulus
    logic        got_lock;
    int unsigned ch;
    int unsigned slips_before;
    arst_n_i   = 1'b0;
    reg_we     = 1'b0;
    reg_re     = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    corrupt    = '0;
    check_en   = 1'b0;
    cyc        = 0;
    quiet_until = 0;
    n_mismatch = 0;
    n_other    = 0;
    n_checks   = 0;
    lfsr       = 32'hcbcb_8495;
    for (int c = 0; c < N; c++) begin
      rx_data[c]   = '0;
      offset[c]    = rand_bits(6) % `RX_WORD_W;  // Random starting alignment
      base[c]      = c * 100;
      exp_sel[c]   = c;
      exp_depth[c] = `RX_DEPTH_RESET;
      slip_cnt[c]  = 0;
      last_slip[c] = 0;
      chk_cnt[c]   = 0;
    end

    repeat (8) @(posedge gt_clkout);
    arst_n_i <= 1'b1;
    @(posedge gt_clkout);
    assert (locked == '0 && valid == '0 && slip == '0) else begin
      n_other++;
      $display("outputs not idle after reset at %0t", $time);
    end

    // True lock means the model offset is back at zero
    got_lock = 1'b0;
    for (int i = 0; i < LOCK_BOUND && !got_lock; i++) begin
      @(posedge gt_clkout);
      got_lock = 1'b1;
      for (int c = 0; c < N; c++) begin
        if (!locked[c] || offset[c] != 0) got_lock = 1'b0;
      end
    end
    if (!got_lock) begin
      n_other++;
      $display("channels failed to lock within %0d cycles", LOCK_BOUND);
    end
    check_reg(4'd4, 32'hf, "STATUS");
    check_reg(4'd1, 32'he4, "MUX");
    check_en    <= 1'b1;
    quiet_until <= cyc + QUIET + 4;
    repeat (60) @(posedge gt_clkout);

    // Depth control with saturation at both ends
    check_reg(4'd5, 32'h4444, "DEPTH");
    step_depth(4'd2, 4'b0001);
    step_depth(4'd3, 4'b0010);
    repeat (5) step_depth(4'd2, 4'b0100);
    repeat (12) step_depth(4'd3, 4'b1000);
    repeat (60) @(posedge gt_clkout);
    check_reg(4'd5, 32'hf053, "DEPTH");
    write_reg(4'd0, 32'h1);
    for (int k = 0; k < N; k++) begin
      exp_depth[k] <= `RX_DEPTH_RESET;
    end
    quiet_until <= cyc + QUIET + 4;
    repeat (60) @(posedge gt_clkout);
    check_reg(4'd5, 32'h4444, "DEPTH");

    // Permuted crossbar out0<-2 out1<-0 out2<-3 out3<-1
    write_reg(4'd1, 32'h72);
    exp_sel[0]  <= 2;
    exp_sel[1]  <= 0;
    exp_sel[2]  <= 3;
    exp_sel[3]  <= 1;
    quiet_until <= cyc + QUIET + 4;
    repeat (60) @(posedge gt_clkout);
    check_reg(4'd1, 32'h72, "MUX");

    // Single header bit error on a random channel at a random instant
    ch = rand_bits(2);
    repeat (rand_bits(5)) @(posedge gt_clkout);
    slips_before = slip_cnt[ch];
    @(posedge gt_clkout);
    corrupt[ch] <= 1'b1;
    @(posedge gt_clkout);
    corrupt[ch] <= 1'b0;
    got_lock = 1'b1;
    for (int i = 0; i < 10 && got_lock; i++) begin
      @(posedge gt_clkout);
      got_lock = locked[ch];
    end
    if (got_lock) begin
      n_other++;
      $display("channel %0d kept its lock through a bad header", ch);
    end
    check_reg(4'd4, 32'hf & ~(32'h1 << ch), "STATUS");
    for (int i = 0; i < 4 * `RX_LOCK_COUNT && !got_lock; i++) begin
      @(posedge gt_clkout);
      got_lock = locked[ch];
    end
    if (!got_lock) begin
      n_other++;
      $display("channel %0d did not lock again after a bad header", ch);
    end
    if (slip_cnt[ch] != slips_before) begin
      n_other++;
      $display("channel %0d slipped while locking again", ch);
    end
    check_reg(4'd4, 32'hf, "STATUS");
    repeat (40) @(posedge gt_clkout);

    for (int k = 0; k < N; k++) begin
      if (chk_cnt[k] == 0) begin
        n_other++;
        $display("no payload word was ever checked on output channel %0d", k);
      end
    end
    $display("errors: %0d mismatch, %0d other, %0d payload checks",
             n_mismatch, n_other, n_checks);
    if (n_mismatch == 0 && n_other == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+hdl
hdl/dts_rx_pkg.sv
hdl/dts_deformatter.sv
hdl/dts_reorder.sv
hdl/dts_offsetter.sv
hdl/dts_rx_regs.sv
hdl/dts_rx.sv
testbench/tb_dts_rx.sv

//--- Bender.yml
package:
  name: dts_rx

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dts_rx_pkg.sv
      - hdl/dts_deformatter.sv
      - hdl/dts_reorder.sv
      - hdl/dts_offsetter.sv
      - hdl/dts_rx_regs.sv
      - hdl/dts_rx.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/tb_dts_rx.sv
